// ==== Bender.yml ====
package:
  name: mips_system

sources:
  - src/mips_pkg.sv
  - src/instr_ram.sv
  - src/mips_decode.sv
  - src/mips_execute.sv
  - src/mips_result.sv
  - src/mips_system.sv
  - target: test
    files:
      - tests/tb_mips_system.sv

// ==== build.f ====
src/mips_pkg.sv
src/instr_ram.sv
src/mips_decode.sv
src/mips_execute.sv
src/mips_result.sv
src/mips_system.sv
tests/tb_mips_system.sv

// ==== src/instr_ram.sv ====
module instr_ram (
    // byte address of the fetch, based at the reset vector
    input  mips_pkg::word_t instr_address,
    // instruction word, available in the same cycle
    output mips_pkg::word_t instr_readdata
);

    import mips_pkg::*;

    word_t mem [imem_words];

    // byte offset from the start of the memory
    word_t offset;

    // fields used while assembling the program
    int        w_addr;
    int        i;
    opcode_t   opcode;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    logic [4:0]  shamt;
    funct_t      funct;
    logic [15:0] imm;

    assign offset = instr_address - reset_vector;

    // word aligned combinational read, low two bits ignored
    assign instr_readdata = mem[offset[imem_index_bits+1:2]];

    initial begin
        // everything past the program reads back as a nop
        for (int k = 0; k < imem_words; k++) begin
            mem[k] = '0;
        end
        w_addr = 0;

        // lw ri, (i-2)*4(r0) for r2 up to r31
        for (i = 2; i < 32; i++) begin
            opcode = op_lw;
            rs = 5'd0;
            rt = reg_addr_t'(i);
            imm = 16'((i - 2) * 4);
            mem[w_addr >> 2] = {opcode, rs, rt, imm};
            w_addr += 4;
        end

        // per register: bgez ri, 2 / nop / sw ri, 0x100+(i-2)*4(r0)
        // a non-negative ri jumps over its own store
        for (i = 2; i < 31; i++) begin
            opcode = op_regimm;
            rs = reg_addr_t'(i);
            rt = regimm_bgez;
            imm = 16'd2;
            mem[w_addr >> 2] = {opcode, rs, rt, imm};
            w_addr += 4;

            // delay slot filler
            opcode = op_special;
            rs = 5'd0;
            rt = 5'd0;
            rd = 5'd0;
            shamt = 5'd0;
            funct = fn_sll;
            mem[w_addr >> 2] = {opcode, rs, rt, rd, shamt, funct};
            w_addr += 4;

            // only reached for a negative ri
            opcode = op_sw;
            rs = 5'd0;
            rt = reg_addr_t'(i);
            imm = 16'(16'h100 + (i - 2) * 4);
            mem[w_addr >> 2] = {opcode, rs, rt, imm};
            w_addr += 4;
        end

        // jr r0 ends the run once its delay slot has executed
        opcode = op_special;
        rs = 5'd0;
        rt = 5'd0;
        rd = 5'd0;
        shamt = 5'd0;
        funct = fn_jr;
        mem[w_addr >> 2] = {opcode, rs, rt, rd, shamt, funct};
        w_addr += 4;

        // delay slot of the jr
        funct = fn_sll;
        mem[w_addr >> 2] = {opcode, rs, rt, rd, shamt, funct};
    end

endmodule

// ==== src/mips_decode.sv ====
module mips_decode (
    input  logic                clk,
    input  logic                rst_n,
    // instruction fetched this cycle
    input  mips_pkg::word_t     instr,
    // writeback port from the result stage
    input  logic                wb_enable,
    input  mips_pkg::reg_addr_t wb_reg,
    input  mips_pkg::word_t     wb_data,
    // decoded class and operands
    output mips_pkg::ctrl_t     ctrl,
    output mips_pkg::word_t     rs_value,
    output mips_pkg::word_t     rt_value,
    output mips_pkg::word_t     imm,
    output mips_pkg::reg_addr_t rt_reg
);

    import mips_pkg::*;

    // raw instruction fields
    opcode_t     opcode;
    funct_t      funct;
    reg_addr_t   rs_field;
    reg_addr_t   rt_field;
    reg_addr_t   rd_field;
    logic [4:0]  shamt_field;
    logic [15:0] imm_field;

    // general purpose registers
    word_t regs [num_regs];

    assign opcode      = opcode_t'(instr[31:26]);
    assign rs_field    = instr[25:21];
    assign rt_field    = instr[20:16];
    assign rd_field    = instr[15:11];
    assign shamt_field = instr[10:6];
    assign funct       = funct_t'(instr[5:0]);
    assign imm_field   = instr[15:0];

    // i-type offset, sign extended to a full word
    assign imm = {{16{imm_field[15]}}, imm_field};

    // store data and load destination both use rt
    assign rt_reg = rt_field;

    // instruction class
    // anything not recognised falls through as a nop
    always_comb begin
        ctrl = ctrl_nop;
        case (opcode)
            op_special: begin
                case (funct)
                    // jr carries zero in rt, rd and shamt
                    fn_jr: begin
                        if (rt_field == '0 && rd_field == '0 && shamt_field == '0) begin
                            ctrl = ctrl_jr;
                        end
                    end
                    // shifts are not implemented, sll executes as nop
                    fn_sll:  ctrl = ctrl_nop;
                    default: ctrl = ctrl_nop;
                endcase
            end
            op_regimm: begin
                // only the bgez form of regimm
                if (rt_field == regimm_bgez) begin
                    ctrl = ctrl_bgez;
                end
            end
            op_lw:   ctrl = ctrl_load;
            op_sw:   ctrl = ctrl_store;
            default: ctrl = ctrl_nop;
        endcase
    end

    // asynchronous reads, r0 always returns zero
    assign rs_value = (rs_field == '0) ? '0 : regs[rs_field];
    assign rt_value = (rt_field == '0) ? '0 : regs[rt_field];

    // write lands at the rising edge ending the instruction
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < num_regs; r++) begin
                regs[r] <= '0;
            end
        end else if (wb_enable && wb_reg != '0) begin
            regs[wb_reg] <= wb_data;
        end
    end

endmodule

// ==== src/mips_execute.sv ====
module mips_execute (
    // decoded class of the current instruction
    input  mips_pkg::ctrl_t ctrl,
    // address of the current instruction
    input  mips_pkg::word_t pc,
    input  mips_pkg::word_t rs_value,
    // sign extended immediate
    input  mips_pkg::word_t imm,
    // effective address for lw and sw
    output mips_pkg::word_t mem_address,
    // control transfer requested after the delay slot
    output logic            taken,
    // destination of the transfer
    output mips_pkg::word_t target
);

    import mips_pkg::*;

    // address of the instruction in the delay slot
    word_t delay_pc;

    // pc relative destination of a branch
    word_t branch_target;

    // bgez condition, sign bit clear
    logic rs_not_negative;

    // base register plus offset, no byte lanes
    assign mem_address = rs_value + imm;

    assign delay_pc = pc + instr_bytes;

    // offset counts words, relative to the delay slot
    assign branch_target = delay_pc + {imm[29:0], 2'b00};

    assign rs_not_negative = ~rs_value[31];

    always_comb begin
        taken  = 1'b0;
        target = branch_target;
        case (ctrl)
            ctrl_bgez: begin
                // zero counts as non-negative and branches
                taken = rs_not_negative;
            end
            ctrl_jr: begin
                // register indirect, always taken
                taken  = 1'b1;
                target = rs_value;
            end
            default: begin
                taken = 1'b0;
            end
        endcase
    end

endmodule

// ==== src/mips_pkg.sv ====
package mips_pkg;

    // basic data types shared by every block
    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;

    // primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        op_special = 6'b000000,
        op_regimm  = 6'b000001,
        op_lw      = 6'b100011,
        op_sw      = 6'b101011
    } opcode_t;

    // function field of special (r-type) words, bits 5:0
    typedef enum logic [5:0] {
        // sll r0, r0, 0 is the canonical all-zero nop
        fn_sll = 6'b000000,
        fn_jr  = 6'b001000
    } funct_t;

    // decoded instruction class, one per supported instruction
    typedef enum logic [2:0] {
        ctrl_nop,
        ctrl_load,
        ctrl_store,
        ctrl_bgez,
        ctrl_jr
    } ctrl_t;

    // first fetch address after reset
    // also the base address of the instruction memory
    localparam word_t reset_vector = 32'hbfc00000;

    // instruction memory depth in words
    localparam int imem_words = 4096;

    // word index width derived from the depth
    localparam int imem_index_bits = $clog2(imem_words);

    // a jump to this address stops the core
    localparam word_t halt_address = 32'h00000000;

    // rt field selector inside the regimm group
    // 00001 picks bgez, 00000 would be bltz
    localparam reg_addr_t regimm_bgez = 5'd1;

    // register count of the general purpose file
    localparam int num_regs = 32;

    // byte stride between consecutive instruction words
    localparam word_t instr_bytes = 32'd4;

endpackage

// ==== src/mips_result.sv ====
module mips_result (
    input  logic                clk,
    input  logic                rst_n,
    input  mips_pkg::ctrl_t     ctrl,
    input  mips_pkg::reg_addr_t rt_reg,
    input  logic                taken,
    input  mips_pkg::word_t     target,
    // load data from the external memory in the same cycle
    input  mips_pkg::word_t     data_readdata,
    output mips_pkg::word_t     pc,
    output logic                wb_enable,
    output mips_pkg::reg_addr_t wb_reg,
    output mips_pkg::word_t     wb_data,
    output logic                data_read,
    output logic                data_write,
    output logic                active
);

    import mips_pkg::*;

    // marks the idle cycle right after reset
    logic  started;
    // first instruction executes in the cycle after the idle one
    logic  running;
    // sticky once a jump to the halt address completes
    logic  halted;
    // branch or jump waiting for its delay slot
    logic  pending;
    word_t pending_target;
    // current instruction really executes
    logic  executing;

    assign executing = running && !halted;
    assign active    = !halted;

    // memory strobes only while executing
    assign data_read  = executing && (ctrl == ctrl_load);
    assign data_write = executing && (ctrl == ctrl_store);

    // loads write rt at the end of the same cycle
    assign wb_enable = data_read && (rt_reg != '0);
    assign wb_reg    = rt_reg;
    assign wb_data   = data_readdata;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc      <= reset_vector;
            started <= 1'b0;
            running <= 1'b0;
            halted  <= 1'b0;
            pending <= 1'b0;
        end else if (!started) begin
            started <= 1'b1;
        end else if (!running) begin
            running <= 1'b1;
        end else if (!halted) begin
            if (pending) begin
                // take the stored destination once the delay slot is done
                pending <= 1'b0;
                pc      <= pending_target;
                if (pending_target == halt_address) begin
                    halted <= 1'b1;
                end
            end else begin
                pc <= pc + instr_bytes;
                pending <= taken;
            end
        end
    end

    // destination held over the delay slot
    always_ff @(posedge clk) begin
        if (executing && !pending && taken) begin
            pending_target <= target;
        end
    end

endmodule

// ==== src/mips_system.sv ====
module mips_system (
    input  logic            clk,
    input  logic            rst_n,
    // external data memory, answers in the same cycle
    input  mips_pkg::word_t data_readdata,
    output mips_pkg::word_t data_address,
    output mips_pkg::word_t data_writedata,
    output logic            data_read,
    output logic            data_write,
    // low once the core has halted
    output logic            active
);

    import mips_pkg::*;

    // fetch path
    word_t     pc;
    word_t     instr;

    // decode outputs
    ctrl_t     ctrl;
    word_t     rs_value;
    word_t     imm;
    reg_addr_t rt_reg;

    // execute outputs
    logic      taken;
    word_t     target;

    // writeback path back into the register file
    logic      wb_enable;
    reg_addr_t wb_reg;
    word_t     wb_data;

    instr_ram u_instr_ram (
        .instr_address  (pc),
        .instr_readdata (instr)
    );

    // rt_value doubles as the store data
    mips_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .instr     (instr),
        .wb_enable (wb_enable),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data),
        .ctrl      (ctrl),
        .rs_value  (rs_value),
        .rt_value  (data_writedata),
        .imm       (imm),
        .rt_reg    (rt_reg)
    );

    mips_execute u_execute (
        .ctrl        (ctrl),
        .pc          (pc),
        .rs_value    (rs_value),
        .imm         (imm),
        .mem_address (data_address),
        .taken       (taken),
        .target      (target)
    );

    mips_result u_result (
        .clk           (clk),
        .rst_n         (rst_n),
        .ctrl          (ctrl),
        .rt_reg        (rt_reg),
        .taken         (taken),
        .target        (target),
        .data_readdata (data_readdata),
        .pc            (pc),
        .wb_enable     (wb_enable),
        .wb_reg        (wb_reg),
        .wb_data       (wb_data),
        .data_read     (data_read),
        .data_write    (data_write),
        .active        (active)
    );

endmodule

// ==== tests/mips_golden.txt ====
// column 1: byte address of the load, column 2: word the data memory returns
// rows are in program order, r2 first and r31 last
00000000 00000000
00000004 80000000
00000008 12345678
0000000c ffffffff
00000010 7fffffff
00000014 deadbeef
00000018 00000001
0000001c 80000001
00000020 cafef00d
00000024 0badf00d
00000028 00000000
0000002c fedcba98
00000030 01234567
00000034 a5a5a5a5
00000038 5a5a5a5a
0000003c c0000000
00000040 3fffffff
00000044 fffffffe
00000048 00010000
0000004c 87654321
00000050 76543210
00000054 00000000
00000058 9abcdef0
0000005c 13579bdf
00000060 f0f0f0f0
00000064 0f0f0f0f
00000068 e0000001
0000006c 2468ace0
00000070 b0000000
00000074 ffff0000

// ==== tests/tb_mips_system.sv ====
module tb_mips_system;

    timeunit 1ns;
    timeprecision 1ps;

    import mips_pkg::*;

    // program shape, thirty loads then one branch group per r2 to r30
    localparam int num_loads       = 30;
    localparam int num_branch_regs = 29;
    localparam int halt_timeout    = 2000;
    localparam int quiet_cycles    = 20;
    localparam int reset_cycles    = 4;
    localparam word_t store_base   = 32'h00000100;

    logic  clk;
    logic  rst_n;
    word_t data_readdata;
    word_t data_address;
    word_t data_writedata;
    logic  data_read;
    logic  data_write;
    logic  active;

    // even entries hold load addresses, odd entries the returned words
    word_t golden [2*num_loads];

    // bus activity seen by the monitor, in order
    word_t load_addr_q [$];
    word_t store_addr_q [$];
    word_t store_data_q [$];

    int checks;
    int errors;

    mips_system u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .data_readdata  (data_readdata),
        .data_address   (data_address),
        .data_writedata (data_writedata),
        .data_read      (data_read),
        .data_write     (data_write),
        .active         (active)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // data memory contents come only from the golden table
    function automatic word_t lookup_word(input word_t address);
        word_t value;
        value = '0;
        for (int k = 0; k < num_loads; k++) begin
            if (golden[2*k] == address) begin
                value = golden[2*k+1];
            end
        end
        return value;
    endfunction

    task automatic check_word(input word_t actual, input word_t expected, input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %0t ns: %s is %08h, expected %08h", $time, what, actual, expected);
        end else begin
            $display("ok %s = %08h", what, actual);
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %0t ns: %s is %b, expected %b", $time, what, actual, expected);
        end else begin
            $display("ok %s = %b", what, actual);
        end
    endtask

    // bus monitor and memory model
    // address and strobes only move at the rising edge, so they are settled here
    always @(negedge clk) begin
        if (data_read === 1'b1) begin
            load_addr_q.push_back(data_address);
        end
        if (data_write === 1'b1) begin
            store_addr_q.push_back(data_address);
            store_data_q.push_back(data_writedata);
        end
        data_readdata = lookup_word(data_address);
    end

    initial begin
        word_t exp_addr_q [$];
        word_t exp_data_q [$];
        int    cycles;
        int    quiet_strobes;

        rst_n         = 1'b0;
        data_readdata = '0;
        checks        = 0;
        errors        = 0;
        quiet_strobes = 0;
        $readmemh("tests/mips_golden.txt", golden);

        // strobes must stay quiet in reset and on the first cycle after it
        for (int c = 0; c < reset_cycles; c++) begin
            @(negedge clk);
            check_flag(data_read, 1'b0, $sformatf("data_read in reset cycle %0d", c));
            check_flag(data_write, 1'b0, $sformatf("data_write in reset cycle %0d", c));
            check_flag(active, 1'b1, $sformatf("active in reset cycle %0d", c));
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_flag(data_read, 1'b0, "data_read after reset");
        check_flag(data_write, 1'b0, "data_write after reset");
        check_flag(active, 1'b1, "active after reset");

        // run the program until the jr r0 halts the core
        cycles = 0;
        while (active !== 1'b0 && cycles < halt_timeout) begin
            @(negedge clk);
            cycles++;
        end

        checks++;
        if (active !== 1'b0) begin
            errors++;
            $display("core did not halt within %0d cycles", halt_timeout);
        end else begin
            $display("ok core halted after %0d cycles", cycles);

            // a halted core must not touch the bus again
            for (int c = 0; c < quiet_cycles; c++) begin
                @(negedge clk);
                if (data_read !== 1'b0 || data_write !== 1'b0) begin
                    quiet_strobes++;
                end
            end
            check_word(word_t'(quiet_strobes), '0, "strobes after halt");

            // loads follow golden file order
            check_word(word_t'(load_addr_q.size()), word_t'(num_loads), "load count");
            for (int k = 0; k < num_loads && k < load_addr_q.size(); k++) begin
                check_word(load_addr_q[k], golden[2*k], $sformatf("load address %0d", k));
            end

            // only registers loaded with a negative word skip their branch
            for (int k = 0; k < num_branch_regs; k++) begin
                if (golden[2*k+1][31]) begin
                    exp_addr_q.push_back(store_base + word_t'(k * 4));
                    exp_data_q.push_back(golden[2*k+1]);
                end
            end
            check_word(word_t'(store_addr_q.size()), word_t'(exp_addr_q.size()), "store count");
            for (int k = 0; k < exp_addr_q.size() && k < store_addr_q.size(); k++) begin
                check_word(store_addr_q[k], exp_addr_q[k], $sformatf("store address %0d", k));
                check_word(store_data_q[k], exp_data_q[k], $sformatf("store data %0d", k));
            end
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
